/* flist.f */
source/l2_pkg.sv
source/l2_array_if.sv
source/l2_plru.sv
source/l2_tag_lookup.sv
source/l2_ctrl_fsm.sv
source/l2_data_store.sv
source/l2_cache_top.sv
bench/tb_clock.sv
bench/l2_mem_model.sv
bench/l2_cache_tb.sv

/* Makefile */
TOOL    := verilator
FLAGS   := --binary --timing
TOP     := l2_cache_tb
RTL_TOP := l2_cache_top
FLIST   := flist.f
BUILD   := obj_dir
LOG     := sim.log

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

.PHONY: all build run lint clean

/* bench/l2_cache_tb.sv */
`timescale 1ns/1ps

module l2_cache_tb;
    localparam int index_width    = 4;
    localparam int offset_width   = 2;
    localparam int words          = 1 << offset_width;
    localparam int line_width     = 32 * words;
    localparam int n_ops          = 31;
    localparam int timeout_cycles = n_ops * 40 + 100;
    localparam int evict_first    = 14;   // five tags into set 5
    localparam int evict_last     = 18;

    logic                  clk;
    logic                  rstn;
    logic                  cpu_req, cpu_wr, cpu_addr_ok, cpu_data_ok;
    logic [31:0]           cpu_addr, cpu_wdata, cpu_rdata;
    logic                  mem_req_r, mem_req_w, mem_rdy;
    logic                  mem_addr_ok_r, mem_addr_ok_w, mem_data_ok;
    logic [31:0]           mem_addr;
    logic [line_width-1:0] mem_wdata, mem_rdata;
    int                    read_count, wb_count;

    // stimulus table
    logic                  op_wr    [n_ops];
    logic [31:0]           op_addr  [n_ops];
    logic [31:0]           op_data  [n_ops];
    logic [31:0]           op_exp   [n_ops];
    int                    op_fills [n_ops];   // expected line reads, -1 when unknown
    int                    n_built;
    logic [31:0]           shadow [logic [31:0]];
    int                    data_errors, count_errors, wb_errors, bus_errors;
    int                    wb_mark;
    int                    cycles;

    tb_clock u_clock (.clk_o(clk));

    l2_cache_top #(.index_width(index_width), .offset_width(offset_width)) uut (
        .clk             (clk),
        .rstn            (rstn),
        .cpu_req_i       (cpu_req),
        .cpu_wr_i        (cpu_wr),
        .cpu_addr_i      (cpu_addr),
        .cpu_wdata_i     (cpu_wdata),
        .cpu_addr_ok_o   (cpu_addr_ok),
        .cpu_data_ok_o   (cpu_data_ok),
        .cpu_rdata_o     (cpu_rdata),
        .mem_req_r_o     (mem_req_r),
        .mem_req_w_o     (mem_req_w),
        .mem_rdy_o       (mem_rdy),
        .mem_addr_ok_r_i (mem_addr_ok_r),
        .mem_addr_ok_w_i (mem_addr_ok_w),
        .mem_data_ok_i   (mem_data_ok),
        .mem_addr_o      (mem_addr),
        .mem_wdata_o     (mem_wdata),
        .mem_rdata_i     (mem_rdata)
    );

    l2_mem_model #(.offset_width(offset_width)) u_mem (
        .clk             (clk),
        .rstn            (rstn),
        .mem_req_r_i     (mem_req_r),
        .mem_req_w_i     (mem_req_w),
        .mem_rdy_i       (mem_rdy),
        .mem_addr_i      (mem_addr),
        .mem_wdata_i     (mem_wdata),
        .mem_addr_ok_r_o (mem_addr_ok_r),
        .mem_addr_ok_w_o (mem_addr_ok_w),
        .mem_data_ok_o   (mem_data_ok),
        .mem_rdata_o     (mem_rdata),
        .read_count_o    (read_count),
        .wb_count_o      (wb_count)
    );

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        if (shadow.exists(addr)) return shadow[addr];
        return addr ^ 32'h5a5a0000;
    endfunction

    task automatic add_op(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                          input int fills);
        if (n_built < n_ops) begin
            op_wr[n_built]    = wr;
            op_addr[n_built]  = addr;
            op_data[n_built]  = data;
            op_fills[n_built] = fills;
        end
        n_built++;
    endtask

    ////////////////////////////////////////////////////////////
    // table contents
    ////////////////////////////////////////////////////////////

    task automatic build_table();
        add_op(1'b0, 32'h0000_1000, 32'h0, 1);   // fresh lines
        add_op(1'b0, 32'h0000_1024, 32'h0, 1);
        add_op(1'b0, 32'h0000_1004, 32'h0, 0);   // same line
        add_op(1'b0, 32'h0000_100c, 32'h0, 0);
        add_op(1'b0, 32'h0000_1028, 32'h0, 0);
        add_op(1'b1, 32'h0000_1008, 32'hdead_beef, 0);   // write hit
        add_op(1'b0, 32'h0000_1008, 32'h0, 0);
        add_op(1'b0, 32'h0000_1004, 32'h0, 0);
        add_op(1'b0, 32'h0000_1000, 32'h0, 0);
        add_op(1'b1, 32'h0000_2034, 32'h1234_5678, 1);   // write miss
        add_op(1'b0, 32'h0000_2034, 32'h0, 0);
        add_op(1'b0, 32'h0000_2030, 32'h0, 0);
        add_op(1'b0, 32'h0000_2038, 32'h0, 0);
        add_op(1'b0, 32'h0000_203c, 32'h0, 0);
        for (int t = 0; t < 5; t++) add_op(1'b1, 32'h0000_3050 + (t << 8), 32'ha5a5_0000 + t, 1);
        for (int t = 0; t < 5; t++) add_op(1'b0, 32'h0000_3050 + (t << 8), 32'h0, -1);
        add_op(1'b1, 32'h0000_3454, 32'h0bad_cafe, -1);
        add_op(1'b0, 32'h0000_3454, 32'h0, -1);
        for (int t = 1; t < 5; t++) add_op(1'b0, 32'h0000_1000 + (t << 8), 32'h0, 1);
        add_op(1'b0, 32'h0000_1008, 32'h0, -1);   // dirty line back from memory
    endtask

    task automatic run_op(input int i);
        int reads_before;
        int waited;
        reads_before = read_count;
        waited       = 0;
        @(posedge clk);
        cpu_req   <= 1'b1;
        cpu_wr    <= op_wr[i];
        cpu_addr  <= op_addr[i];
        cpu_wdata <= op_data[i];
        do @(negedge clk); while (!cpu_addr_ok);
        @(posedge clk);   // accept edge
        cpu_req <= 1'b0;
        if (op_wr[i]) begin
            do begin
                @(negedge clk);
                if (cpu_data_ok) begin
                    bus_errors++;
                    $display("CHECK FAILED at %0t: write to %08h raised cpu_data_ok",
                             $time, op_addr[i]);
                end
            end while (!cpu_addr_ok);
            shadow[op_addr[i]] = op_data[i];
        end else begin
            do begin
                @(negedge clk);
                waited++;
            end while (!cpu_data_ok);
            if (op_fills[i] == 0 && waited != 1) begin
                bus_errors++;
                $display("CHECK FAILED at %0t: read hit of %08h took %0d cycles, expected 1",
                         $time, op_addr[i], waited);
            end
            if (cpu_rdata !== op_exp[i]) begin
                data_errors++;
                $display("CHECK FAILED at %0t: read of %08h returned %08h, expected %08h",
                         $time, op_addr[i], cpu_rdata, op_exp[i]);
            end
        end
        if (op_fills[i] >= 0 && read_count - reads_before != op_fills[i]) begin
            count_errors++;
            $display("CHECK FAILED at %0t: access to %08h made %0d line reads, expected %0d",
                     $time, op_addr[i], read_count - reads_before, op_fills[i]);
        end
    endtask

    task automatic check_writeback();
        logic [31:0] addr;
        logic [31:0] want;
        for (int w = 0; w < words; w++) begin
            addr = mem_addr + 32'(4 * w);
            want = shadow_word(addr);
            if (mem_wdata[w*32 +: 32] !== want) begin
                wb_errors++;
                $display("CHECK FAILED at %0t: writeback word %08h is %08h, expected %08h",
                         $time, addr, mem_wdata[w*32 +: 32], want);
            end
        end
    endtask

    always @(negedge clk) begin
        if (rstn) begin
            if (mem_req_r && mem_req_w) begin
                bus_errors++;
                $display("CHECK FAILED at %0t: memory read and write requests high together",
                         $time);
            end
            if (mem_req_w && mem_addr_ok_w) check_writeback();
        end
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycles);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rstn         = 1'b0;
        cpu_req      = 1'b0;
        cpu_wr       = 1'b0;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        data_errors  = 0;
        count_errors = 0;
        wb_errors    = 0;
        bus_errors   = 0;
        wb_mark      = 0;
        n_built      = 0;
        build_table();
        if (n_built != n_ops) begin
            count_errors++;
            $display("stimulus table has %0d entries instead of %0d", n_built, n_ops);
        end
        for (int i = 0; i < n_ops; i++) begin   // expected values from the shadow map
            if (op_wr[i]) shadow[op_addr[i]] = op_data[i];
            op_exp[i] = shadow_word(op_addr[i]);
        end
        shadow.delete();

        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        if (!cpu_addr_ok || cpu_data_ok || mem_req_r || mem_req_w || mem_rdy) begin
            bus_errors++;
            $display("CHECK FAILED at %0t: outputs after reset are not idle", $time);
        end

        for (int i = 0; i < n_ops; i++) begin
            if (i == evict_first) wb_mark = wb_count;
            run_op(i);
            if (i == evict_last && wb_count <= wb_mark) begin
                count_errors++;
                $display("CHECK FAILED at %0t: five tags in one set gave no writeback", $time);
            end
        end

        $display("errors: data %0d, counters %0d, writeback %0d, bus %0d",
                 data_errors, count_errors, wb_errors, bus_errors);
        if (data_errors + count_errors + wb_errors + bus_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* bench/l2_mem_model.sv */
`timescale 1ns/1ps

module l2_mem_model #(
    parameter int offset_width = 2
) (
    input  logic                                        clk,
    input  logic                                        rstn,
    input  logic                                        mem_req_r_i,
    input  logic                                        mem_req_w_i,
    input  logic                                        mem_rdy_i,
    input  logic [l2_pkg::ADDR_W-1:0]                   mem_addr_i,
    input  logic [(l2_pkg::WORD_W << offset_width)-1:0] mem_wdata_i,
    output logic                                        mem_addr_ok_r_o,
    output logic                                        mem_addr_ok_w_o,
    output logic                                        mem_data_ok_o,
    output logic [(l2_pkg::WORD_W << offset_width)-1:0] mem_rdata_o,
    output int                                          read_count_o,
    output int                                          wb_count_o
);
    localparam int words      = 1 << offset_width;
    localparam int line_width = l2_pkg::WORD_W * words;

    logic [l2_pkg::WORD_W-1:0] stored [logic [l2_pkg::ADDR_W-1:0]];   // written back words
    logic                      ok_r    = 1'b0;
    logic                      ok_w    = 1'b0;
    logic                      data_ok = 1'b0;
    logic [line_width-1:0]     rdata   = '0;
    logic                      pend_r  = 1'b0;
    logic [l2_pkg::ADDR_W-1:0] rd_addr = '0;
    int                        wait_w  = -1;
    int                        wait_a  = -1;
    int                        wait_d  = -1;
    int                        reads   = 0;
    int                        wbs     = 0;
    integer                    seed;

    initial seed = 32'h7f7591d8;

    assign mem_addr_ok_r_o = ok_r;
    assign mem_addr_ok_w_o = ok_w;
    assign mem_data_ok_o   = data_ok;
    assign mem_rdata_o     = rdata;
    assign read_count_o    = reads;
    assign wb_count_o      = wbs;

    function automatic logic [l2_pkg::WORD_W-1:0] word_at(input logic [l2_pkg::ADDR_W-1:0] addr);
        if (stored.exists(addr)) return stored[addr];
        return addr ^ 32'h5a5a0000;   // untouched memory
    endfunction

    function automatic logic [line_width-1:0] read_line(input logic [l2_pkg::ADDR_W-1:0] base);
        logic [line_width-1:0] line;
        for (int i = 0; i < words; i++) begin
            line[i*l2_pkg::WORD_W +: l2_pkg::WORD_W] = word_at(base + 32'(4 * i));
        end
        return line;
    endfunction

    always @(posedge clk) begin
        if (!rstn) begin
            ok_r    <= 1'b0;
            ok_w    <= 1'b0;
            data_ok <= 1'b0;
            pend_r  <= 1'b0;
            wait_w  <= -1;
            wait_a  <= -1;
            wait_d  <= -1;
        end else begin
            // write channel, whole line
            if (mem_req_w_i && ok_w) begin
                for (int i = 0; i < words; i++) begin
                    stored[mem_addr_i + 32'(4 * i)] = mem_wdata_i[i*l2_pkg::WORD_W +: l2_pkg::WORD_W];
                end
                wbs    <= wbs + 1;
                ok_w   <= 1'b0;
                wait_w <= -1;
            end else if (mem_req_w_i) begin
                if (wait_w < 0) wait_w <= $unsigned($random(seed)) % 4;
                else if (wait_w == 0) ok_w <= 1'b1;
                else wait_w <= wait_w - 1;
            end

            // read request
            if (mem_req_r_i && ok_r) begin
                rd_addr <= mem_addr_i;
                pend_r  <= 1'b1;
                reads   <= reads + 1;
                ok_r    <= 1'b0;
                wait_a  <= -1;
            end else if (mem_req_r_i) begin
                if (wait_a < 0) wait_a <= $unsigned($random(seed)) % 4;
                else if (wait_a == 0) ok_r <= 1'b1;
                else wait_a <= wait_a - 1;
            end

            // read data
            if (pend_r && mem_rdy_i) begin
                if (data_ok) begin
                    data_ok <= 1'b0;
                    pend_r  <= 1'b0;
                    wait_d  <= -1;
                end else if (wait_d < 0) begin
                    wait_d <= $unsigned($random(seed)) % 4;
                end else if (wait_d == 0) begin
                    data_ok <= 1'b1;
                    rdata   <= read_line(rd_addr);
                end else begin
                    wait_d <= wait_d - 1;
                end
            end
        end
    end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period = 10   // 20 ns period
) (
    output logic clk_o
);
    initial clk_o = 1'b0;

    always #(half_period) clk_o = ~clk_o;

endmodule

/* source/l2_cache_top.sv */
`timescale 1ns/1ps

module l2_cache_top #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                                        clk,
    input  logic                                        rstn,
    // cpu side
    input  logic                                        cpu_req_i,
    input  logic                                        cpu_wr_i,
    input  logic [l2_pkg::ADDR_W-1:0]                   cpu_addr_i,
    input  logic [l2_pkg::WORD_W-1:0]                   cpu_wdata_i,
    output logic                                        cpu_addr_ok_o,
    output logic                                        cpu_data_ok_o,
    output logic [l2_pkg::WORD_W-1:0]                   cpu_rdata_o,
    // memory side
    output logic                                        mem_req_r_o,
    output logic                                        mem_req_w_o,
    output logic                                        mem_rdy_o,
    input  logic                                        mem_addr_ok_r_i,
    input  logic                                        mem_addr_ok_w_i,
    input  logic                                        mem_data_ok_i,
    output logic [l2_pkg::ADDR_W-1:0]                   mem_addr_o,
    output logic [(l2_pkg::WORD_W << offset_width)-1:0] mem_wdata_o,
    input  logic [(l2_pkg::WORD_W << offset_width)-1:0] mem_rdata_i
);

    l2_array_if #(.index_width(index_width), .offset_width(offset_width)) arr ();

    l2_tag_lookup #(.index_width(index_width), .offset_width(offset_width)) u_tags (
        .clk         (clk),
        .rstn        (rstn),
        .cpu_req_i   (cpu_req_i),
        .cpu_wr_i    (cpu_wr_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .arr         (arr.tags)
    );

    l2_ctrl_fsm #(.index_width(index_width), .offset_width(offset_width)) u_ctrl (
        .clk             (clk),
        .rstn            (rstn),
        .cpu_req_i       (cpu_req_i),
        .cpu_addr_ok_o   (cpu_addr_ok_o),
        .cpu_data_ok_o   (cpu_data_ok_o),
        .mem_req_r_o     (mem_req_r_o),
        .mem_req_w_o     (mem_req_w_o),
        .mem_rdy_o       (mem_rdy_o),
        .mem_addr_ok_r_i (mem_addr_ok_r_i),
        .mem_addr_ok_w_i (mem_addr_ok_w_i),
        .mem_data_ok_i   (mem_data_ok_i),
        .mem_addr_o      (mem_addr_o),
        .mem_wdata_o     (mem_wdata_o),
        .arr             (arr.ctrl)
    );

    l2_data_store #(.index_width(index_width), .offset_width(offset_width)) u_data (
        .clk         (clk),
        .mem_rdata_i (mem_rdata_i),
        .cpu_rdata_o (cpu_rdata_o),
        .arr         (arr.data)
    );

endmodule

/* source/l2_data_store.sv */
`timescale 1ns/1ps

module l2_data_store #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                                        clk,
    input  logic [(l2_pkg::WORD_W << offset_width)-1:0] mem_rdata_i,
    output logic [l2_pkg::WORD_W-1:0]                   cpu_rdata_o,
    l2_array_if.data                                    arr
);
    localparam int sets       = 1 << index_width;
    localparam int line_width = l2_pkg::WORD_W << offset_width;

    logic [line_width-1:0] data_mem [l2_pkg::WAYS][sets];
    logic [line_width-1:0] sel_line;
    logic [line_width-1:0] rd_line;

    ////////////////////////////////////////////////////////////
    // line array
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (arr.line_we) begin
            data_mem[arr.way_sel][arr.index] <= mem_rdata_i;
        end else if (arr.word_we) begin
            data_mem[arr.way_sel][arr.index][arr.offset*l2_pkg::WORD_W +: l2_pkg::WORD_W]
                <= arr.req_wdata;
        end
    end

    assign sel_line        = data_mem[arr.way_sel][arr.index];
    assign arr.victim_line = sel_line;   // way_sel holds the victim during writeback

    // refill data goes straight through on a read miss
    assign rd_line     = arr.line_we ? mem_rdata_i : sel_line;
    assign cpu_rdata_o = rd_line[arr.offset*l2_pkg::WORD_W +: l2_pkg::WORD_W];

    line_word_excl_a: assert property (@(posedge clk) !(arr.line_we && arr.word_we));

endmodule

/* source/l2_ctrl_fsm.sv */
`timescale 1ns/1ps

module l2_ctrl_fsm #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      cpu_req_i,
    output logic                      cpu_addr_ok_o,
    output logic                      cpu_data_ok_o,
    output logic                      mem_req_r_o,
    output logic                      mem_req_w_o,
    output logic                      mem_rdy_o,
    input  logic                      mem_addr_ok_r_i,
    input  logic                      mem_addr_ok_w_i,
    input  logic                      mem_data_ok_i,
    output logic [l2_pkg::ADDR_W-1:0] mem_addr_o,
    output logic [(l2_pkg::WORD_W << offset_width)-1:0] mem_wdata_o,
    l2_array_if.ctrl                  arr
);
    localparam int line_lsb  = offset_width + l2_pkg::BYTE_OFF_W;
    localparam int tag_width = l2_pkg::ADDR_W - index_width - line_lsb;

    l2_pkg::l2_state_e        state_q, state_d;
    logic [l2_pkg::WAY_W-1:0] vic_way_q;
    logic                     any_hit;
    logic [tag_width-1:0]     req_tag;

    assign any_hit = |arr.hit;
    assign req_tag = arr.req_addr[l2_pkg::ADDR_W-1 -: tag_width];

    always_ff @(posedge clk) begin
        if (!rstn) state_q <= l2_pkg::idle;
        else state_q <= state_d;
    end

    // held from the miss on, the lru update at refill cannot move it
    always_ff @(posedge clk) begin
        if (state_q == l2_pkg::lookup && !any_hit) vic_way_q <= arr.victim_way;
    end

    ////////////////////////////////////////////////////////////
    // next state and strobes
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d       = state_q;
        cpu_addr_ok_o = 1'b0;
        cpu_data_ok_o = 1'b0;
        mem_req_r_o   = 1'b0;
        mem_req_w_o   = 1'b0;
        mem_rdy_o     = 1'b0;
        arr.req_load  = 1'b0;
        arr.way_sel   = vic_way_q;
        arr.use_hit   = 1'b0;
        arr.line_we   = 1'b0;
        arr.word_we   = 1'b0;
        arr.tag_we    = 1'b0;
        arr.dirty_set = 1'b0;
        arr.dirty_clr = 1'b0;
        case (state_q)
            l2_pkg::idle: begin
                cpu_addr_ok_o = 1'b1;
                arr.req_load  = 1'b1;
                if (cpu_req_i) state_d = l2_pkg::lookup;
            end
            l2_pkg::lookup: begin
                arr.way_sel = arr.hit_way;
                if (any_hit) begin
                    arr.use_hit = 1'b1;
                    if (arr.req_wr) begin   // write hit
                        arr.word_we   = 1'b1;
                        arr.dirty_set = 1'b1;
                    end else begin
                        cpu_data_ok_o = 1'b1;
                    end
                    state_d = l2_pkg::idle;
                end else begin
                    state_d = l2_pkg::check_dirty;
                end
            end
            l2_pkg::check_dirty: begin
                state_d = arr.victim_dirty ? l2_pkg::writeback : l2_pkg::refill_req;
            end
            l2_pkg::writeback: begin
                mem_req_w_o = 1'b1;
                if (mem_addr_ok_w_i) state_d = l2_pkg::refill_req;
            end
            l2_pkg::refill_req: begin
                mem_req_r_o = 1'b1;
                if (mem_addr_ok_r_i) state_d = l2_pkg::refill_wait;
            end
            l2_pkg::refill_wait: begin
                mem_rdy_o = 1'b1;
                if (mem_data_ok_i) begin
                    arr.line_we = 1'b1;
                    arr.tag_we  = 1'b1;
                    if (arr.req_wr) begin
                        arr.dirty_set = 1'b1;
                        state_d       = l2_pkg::refill_write;
                    end else begin
                        arr.dirty_clr = 1'b1;
                        arr.use_hit   = 1'b1;
                        cpu_data_ok_o = 1'b1;   // word bypassed from mem_rdata
                        state_d       = l2_pkg::idle;
                    end
                end
            end
            l2_pkg::refill_write: begin
                arr.word_we = 1'b1;
                arr.use_hit = 1'b1;
                state_d     = l2_pkg::idle;
            end
            default: state_d = l2_pkg::idle;
        endcase
    end

    // victim line address on writeback, requested line otherwise
    assign mem_addr_o = (state_q == l2_pkg::writeback)
                      ? {arr.victim_tag, arr.index, {line_lsb{1'b0}}}
                      : {req_tag, arr.index, {line_lsb{1'b0}}};
    assign mem_wdata_o = arr.victim_line;

    mem_req_excl_a: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_req_r_o && mem_req_w_o));

endmodule

/* source/l2_tag_lookup.sv */
`timescale 1ns/1ps

module l2_tag_lookup #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      cpu_req_i,
    input  logic                      cpu_wr_i,
    input  logic [l2_pkg::ADDR_W-1:0] cpu_addr_i,
    input  logic [l2_pkg::WORD_W-1:0] cpu_wdata_i,
    l2_array_if.tags                  arr
);
    localparam int sets      = 1 << index_width;
    localparam int tag_width = l2_pkg::ADDR_W - index_width - offset_width - l2_pkg::BYTE_OFF_W;

    logic [tag_width-1:0]      tag_mem [l2_pkg::WAYS][sets];
    logic [sets-1:0]           valid_q [l2_pkg::WAYS];
    logic [sets-1:0]           dirty_q [l2_pkg::WAYS];
    logic [tag_width-1:0]      req_tag;
    logic [l2_pkg::WAYS-1:0]   plru_use;

    ////////////////////////////////////////////////////////////
    // request buffer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (arr.req_load && cpu_req_i) begin   // accept cycle
            arr.req_wr    <= cpu_wr_i;
            arr.req_addr  <= cpu_addr_i;
            arr.req_wdata <= cpu_wdata_i;
        end
    end

    assign req_tag    = arr.req_addr[l2_pkg::ADDR_W-1 -: tag_width];
    assign arr.index  = arr.req_addr[l2_pkg::BYTE_OFF_W+offset_width +: index_width];
    assign arr.offset = arr.req_addr[l2_pkg::BYTE_OFF_W +: offset_width];

    ////////////////////////////////////////////////////////////
    // compare and victim fields
    ////////////////////////////////////////////////////////////

    always_comb begin
        arr.hit_way = '0;
        for (int w = 0; w < l2_pkg::WAYS; w++) begin
            arr.hit[w] = valid_q[w][arr.index] && (tag_mem[w][arr.index] == req_tag);
            if (arr.hit[w]) arr.hit_way = w[l2_pkg::WAY_W-1:0];
        end
    end

    assign arr.victim_tag   = tag_mem[arr.victim_way][arr.index];
    assign arr.victim_dirty = valid_q[arr.victim_way][arr.index]
                            & dirty_q[arr.victim_way][arr.index];

    assign plru_use = arr.use_hit ? (l2_pkg::WAYS'(1) << arr.way_sel) : '0;

    l2_plru #(
        .index_width (index_width)
    ) u_plru (
        .clk      (clk),
        .rstn     (rstn),
        .index_i  (arr.index),
        .use_i    (plru_use),
        .victim_o (arr.victim_way)
    );

    always_ff @(posedge clk) begin
        if (arr.tag_we) tag_mem[arr.way_sel][arr.index] <= req_tag;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < l2_pkg::WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end else begin
            if (arr.tag_we) valid_q[arr.way_sel][arr.index] <= 1'b1;
            if (arr.dirty_set) dirty_q[arr.way_sel][arr.index] <= 1'b1;
            else if (arr.dirty_clr) dirty_q[arr.way_sel][arr.index] <= 1'b0;
        end
    end

    // a tag is installed only after a miss, so no set holds it twice
    hit_onehot_a: assert property (@(posedge clk) disable iff (!rstn) $onehot0(arr.hit));

endmodule

/* source/l2_plru.sv */
`timescale 1ns/1ps

module l2_plru #(
    parameter int index_width = 4
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [index_width-1:0]   index_i,
    input  logic [l2_pkg::WAYS-1:0]  use_i,
    output logic [l2_pkg::WAY_W-1:0] victim_o
);
    localparam int sets = 1 << index_width;

    // bit 0 root, bit 1 ways 0/1, bit 2 ways 2/3
    logic [2:0] tree_q [sets];
    logic [2:0] tree;
    logic [l2_pkg::WAY_W-1:0] used_way;

    assign tree     = tree_q[index_i];
    assign victim_o = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};
    assign used_way = {use_i[2] | use_i[3], use_i[1] | use_i[3]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < sets; s++) tree_q[s] <= '0;
        end else if (|use_i) begin
            tree_q[index_i][0] <= ~used_way[1];   // point at the other half
            if (used_way[1]) tree_q[index_i][2] <= ~used_way[0];
            else tree_q[index_i][1] <= ~used_way[0];
        end
    end

endmodule

/* source/l2_array_if.sv */
`timescale 1ns/1ps

interface l2_array_if #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
);
    localparam int line_width = l2_pkg::WORD_W << offset_width;
    localparam int tag_width  = l2_pkg::ADDR_W - index_width - offset_width - l2_pkg::BYTE_OFF_W;

    // from the controller
    logic                      req_load;
    logic [l2_pkg::WAY_W-1:0]  way_sel;
    logic                      use_hit;
    logic                      line_we;
    logic                      word_we;
    logic                      tag_we;
    logic                      dirty_set;
    logic                      dirty_clr;

    // from the tag lookup
    logic                      req_wr;
    logic [index_width-1:0]    index;
    logic [offset_width-1:0]   offset;
    logic [l2_pkg::WAYS-1:0]   hit;
    logic [l2_pkg::WAY_W-1:0]  hit_way;
    logic [l2_pkg::WAY_W-1:0]  victim_way;
    logic                      victim_dirty;
    logic [tag_width-1:0]      victim_tag;
    logic [l2_pkg::ADDR_W-1:0] req_addr;
    logic [l2_pkg::WORD_W-1:0] req_wdata;

    // from the data store
    logic [line_width-1:0]     victim_line;

    modport ctrl (
        output req_load, way_sel, use_hit, line_we, word_we, tag_we, dirty_set, dirty_clr,
        input  req_wr, index, hit, hit_way, victim_way, victim_dirty, victim_tag, req_addr,
        input  victim_line
    );

    modport tags (
        input  req_load, way_sel, use_hit, tag_we, dirty_set, dirty_clr,
        output req_wr, index, offset, hit, hit_way, victim_way, victim_dirty, victim_tag,
        output req_addr, req_wdata
    );

    modport data (
        input  line_we, word_we, way_sel, index, offset, req_wdata,
        output victim_line
    );

endinterface

/* source/l2_pkg.sv */
package l2_pkg;

    ////////////////////////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////////////////////////

    localparam int WAYS       = 4;   // fixed by the plru tree
    localparam int WAY_W      = 2;
    localparam int WORD_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int BYTE_OFF_W = 2;   // byte in word

    ////////////////////////////////////////////////////////////
    // controller states
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        idle,
        lookup,
        check_dirty,    // victim dirty bit is looked at here
        writeback,
        refill_req,
        refill_wait,
        refill_write    // write miss, word merge after the refill
    } l2_state_e;

endpackage
